/* include/decode_defines.svh */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define INST_W          32          // instruction word

`define OPCODE_LSB      0
`define OPCODE_W        7
`define FUNCT3_LSB      12
`define FUNCT3_W        3
`define FUNCT7_LSB      25
`define FUNCT7_W        7
`define FUNCT12_LSB     20          // system insts only
`define FUNCT12_W       12

`define MASK_W          8           // store byte enables

`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_OPIMM       7'b0010011
`define OPC_OP          7'b0110011
`define OPC_SYSTEM      7'b1110011

`define F12_ECALL       12'h000
`define F12_EBREAK      12'h001
`define F12_MRET        12'h302

`define F7_BASE         7'b0000000
`define F7_ALT          7'b0100000  // sub and sra

`define DECODE_CREDITS  2           // slots granted by consumer
`define CREDIT_W        2

`endif

/* hw/decodePkg.sv */
package decodePkg;

    // one class per opcode group, system split by funct3/funct12
    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OPIMM,
        CLS_OP,
        CLS_CSRACC,             // csrrw/csrrs/...
        CLS_ECALL,
        CLS_EBREAK,
        CLS_MRET,
        CLS_ILLEGAL             // anything unrecognized
    } instClassE;

    typedef enum logic [2:0] {
        FMT_I = 3'd0,
        FMT_S = 3'd1,
        FMT_R = 3'd2,
        FMT_U = 3'd3,
        FMT_J = 3'd4,
        FMT_B = 3'd5,
        FMT_N = 3'd6            // no operand format
    } instFmtE;

    typedef enum logic [2:0] {
        MEM_BYTE  = 3'd0,
        MEM_HALF  = 3'd1,
        MEM_WORD  = 3'd2,
        MEM_BYTEU = 3'd3,
        MEM_HALFU = 3'd4
    } memTypeE;

    typedef enum logic [2:0] {
        CMP_EQ  = 3'd0,
        CMP_NE  = 3'd1,
        CMP_LT  = 3'd2,
        CMP_GE  = 3'd3,
        CMP_LTU = 3'd4,
        CMP_GEU = 3'd5
    } cmpTypeE;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_SRA = 3'b010,
        ALU_AND = 3'b011,
        ALU_OR  = 3'b100,
        ALU_XOR = 3'b101,
        ALU_SLL = 3'b110,
        ALU_SRL = 3'b111
    } aluOpE;

    typedef enum logic [2:0] {
        RD_ALU  = 3'd0,
        RD_MEM  = 3'd1,
        RD_SNPC = 3'd2,         // pc + 4 for links
        RD_CMP  = 3'd3,
        RD_CSR  = 3'd4,
        RD_NONE = 3'd5          // no writeback
    } rdSrcE;

    typedef enum logic {
        SRC1_REG,
        SRC1_PC
    } aluSrc1E;

    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_IMM,
        SRC2_CSR
    } aluSrc2E;

endpackage

/* hw/opcodeClassifier.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module opcodeClassifier (
    input  logic [`OPCODE_W-1:0]  opcode,
    input  logic [`FUNCT3_W-1:0]  funct3,
    input  logic [`FUNCT12_W-1:0] funct12,
    output decodePkg::instClassE  instClass,
    output decodePkg::instFmtE    instFmt,
    output logic                  isBranch,
    output logic                  isJump,
    output logic                  isEcall,
    output logic                  isMret,
    output logic                  writeCsr,
    output logic                  stopSim
);
    import decodePkg::*;

    always_comb begin
        case (opcode)
            `OPC_LUI:    instClass = CLS_LUI;
            `OPC_AUIPC:  instClass = CLS_AUIPC;
            `OPC_JAL:    instClass = CLS_JAL;
            `OPC_JALR:   instClass = (funct3 == '0) ? CLS_JALR : CLS_ILLEGAL; // funct3 must be 0
            `OPC_BRANCH: instClass = CLS_BRANCH;
            `OPC_LOAD:   instClass = CLS_LOAD;
            `OPC_STORE:  instClass = CLS_STORE;
            `OPC_OPIMM:  instClass = CLS_OPIMM;
            `OPC_OP:     instClass = CLS_OP;
            `OPC_SYSTEM: begin
                if (funct3 != '0) begin
                    instClass = CLS_CSRACC;             // any csr access
                end else begin
                    case (funct12)                      // privileged ops
                        `F12_ECALL:  instClass = CLS_ECALL;
                        `F12_EBREAK: instClass = CLS_EBREAK;
                        `F12_MRET:   instClass = CLS_MRET;
                        default:     instClass = CLS_ILLEGAL; // unknown funct12
                    endcase
                end
            end
            default:     instClass = CLS_ILLEGAL;
        endcase
    end

    always_comb begin
        case (instClass)
            CLS_LUI, CLS_AUIPC:            instFmt = FMT_U;
            CLS_JAL:                       instFmt = FMT_J;
            CLS_JALR, CLS_LOAD, CLS_OPIMM: instFmt = FMT_I;
            CLS_BRANCH:                    instFmt = FMT_B;
            CLS_STORE:                     instFmt = FMT_S;
            CLS_OP:                        instFmt = FMT_R;
            default:                       instFmt = FMT_N; // system and illegal
        endcase
    end

    assign isBranch = instClass == CLS_BRANCH;
    assign isJump   = (instClass == CLS_JAL) || (instClass == CLS_JALR);
    assign isEcall  = instClass == CLS_ECALL;
    assign isMret   = instClass == CLS_MRET;
    assign writeCsr = (instClass == CLS_CSRACC) || (instClass == CLS_ECALL); // ecall saves epc
    assign stopSim  = (instClass == CLS_EBREAK) || (instClass == CLS_ILLEGAL);

endmodule

/* hw/memAccessDecoder.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module memAccessDecoder (
    input  decodePkg::instClassE instClass,
    input  logic [`FUNCT3_W-1:0] funct3,
    output logic                 memValid,
    output logic                 memWrite,
    output logic [`MASK_W-1:0]   memMask,
    output decodePkg::memTypeE   memType
);
    import decodePkg::*;

    assign memValid = (instClass == CLS_LOAD) || (instClass == CLS_STORE);
    assign memWrite = instClass == CLS_STORE;

    always_comb begin
        case (funct3)                                   // width from funct3 only
            3'b000:  memMask = `MASK_W'h01;             // byte
            3'b001:  memMask = `MASK_W'h03;             // half
            3'b010:  memMask = `MASK_W'h0f;             // word
            default: memMask = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  memType = MEM_BYTE;
            3'b001:  memType = MEM_HALF;
            3'b010:  memType = MEM_WORD;
            3'b100:  memType = MEM_BYTEU;               // lbu
            3'b101:  memType = MEM_HALFU;               // lhu
            default: memType = MEM_BYTE;
        endcase
    end

endmodule

/* hw/execControlDecoder.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module execControlDecoder (
    input  decodePkg::instClassE instClass,
    input  logic [`FUNCT3_W-1:0] funct3,
    input  logic [`FUNCT7_W-1:0] funct7,
    output decodePkg::aluOpE     aluOp,
    output decodePkg::cmpTypeE   cmpType,
    output decodePkg::aluSrc1E   aluSrc1,
    output decodePkg::aluSrc2E   aluSrc2,
    output decodePkg::rdSrcE     rdSrc
);
    import decodePkg::*;

    logic isArith;                                      // op or op-imm
    logic setCmp;                                       // slt family

    assign isArith = (instClass == CLS_OP) || (instClass == CLS_OPIMM);

    always_comb begin
        cmpType = CMP_EQ;
        setCmp  = 1'b0;
        if (instClass == CLS_BRANCH) begin
            case (funct3)
                3'b000:  cmpType = CMP_EQ;
                3'b001:  cmpType = CMP_NE;
                3'b100:  cmpType = CMP_LT;
                3'b101:  cmpType = CMP_GE;
                3'b110:  cmpType = CMP_LTU;
                3'b111:  cmpType = CMP_GEU;
                default: cmpType = CMP_EQ;              // reserved encodings
            endcase
        end else if (isArith) begin
            case (funct3)
                3'b010: begin                           // slt/slti
                    cmpType = CMP_LT;
                    setCmp  = 1'b1;
                end
                3'b011: begin                           // sltu/sltiu
                    cmpType = CMP_LTU;
                    setCmp  = 1'b1;
                end
                default: cmpType = CMP_EQ;
            endcase
        end
    end

    always_comb begin
        aluOp = ALU_ADD;                                // addr calc and add
        if ((instClass == CLS_BRANCH) || setCmp) begin
            aluOp = ALU_SUB;                            // compare via subtract
        end else if (isArith) begin
            case (funct3)
                3'b000: begin
                    if ((instClass == CLS_OP) && (funct7 == `F7_ALT)) begin
                        aluOp = ALU_SUB;                // sub, addi never subtracts
                    end
                end
                3'b001: begin
                    if (funct7 == `F7_BASE) begin
                        aluOp = ALU_SLL;
                    end
                end
                3'b101: begin
                    if (funct7 == `F7_BASE) begin
                        aluOp = ALU_SRL;
                    end else if (funct7 == `F7_ALT) begin
                        aluOp = ALU_SRA;
                    end
                end
                3'b100:  aluOp = ALU_XOR;
                3'b110:  aluOp = ALU_OR;
                3'b111:  aluOp = ALU_AND;
                default: aluOp = ALU_ADD;
            endcase
        end
    end

    assign aluSrc1 = (instClass == CLS_AUIPC) ? SRC1_PC : SRC1_REG;

    always_comb begin
        if ((instClass == CLS_OP) || (instClass == CLS_BRANCH)) begin
            aluSrc2 = SRC2_REG;
        end else if (instClass == CLS_CSRACC) begin
            aluSrc2 = SRC2_CSR;
        end else begin
            aluSrc2 = SRC2_IMM;                         // lui gets imm too
        end
    end

    always_comb begin
        if (instClass == CLS_LOAD) begin
            rdSrc = RD_MEM;
        end else if ((instClass == CLS_JAL) || (instClass == CLS_JALR)) begin
            rdSrc = RD_SNPC;                            // link address
        end else if (setCmp) begin
            rdSrc = RD_CMP;
        end else if ((instClass == CLS_CSRACC) || (instClass == CLS_ECALL)) begin
            rdSrc = RD_CSR;
        end else if ((instClass == CLS_BRANCH) || (instClass == CLS_STORE) ||
                     (instClass == CLS_MRET) || (instClass == CLS_EBREAK) ||
                     (instClass == CLS_ILLEGAL)) begin
            rdSrc = RD_NONE;                            // no rd write
        end else begin
            rdSrc = RD_ALU;
        end
    end

endmodule

/* hw/creditCounter.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module creditCounter (
    input  logic clk,
    input  logic rstN,
    input  logic send,                                  // one bundle issued
    input  logic creditReturn,                          // one slot freed downstream
    output logic hasCredit
);

    localparam logic [`CREDIT_W-1:0] creditsFull = `DECODE_CREDITS;

    logic [`CREDIT_W-1:0] creditCnt;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            creditCnt <= creditsFull;                   // consumer starts empty
        end else if (send && !creditReturn) begin
            creditCnt <= creditCnt - 1'b1;
        end else if (creditReturn && !send) begin
            creditCnt <= creditCnt + 1'b1;
        end
    end

    assign hasCredit = creditCnt != '0;

    // issuing with no credit would overrun the consumer
    noSendAtZero: assert property (@(posedge clk) disable iff (!rstN)
        send |-> (creditCnt != '0))
        else $error("send with zero credits");

    // consumer returned more than it was given
    noReturnAtFull: assert property (@(posedge clk) disable iff (!rstN)
        creditReturn |-> (creditCnt != creditsFull))
        else $error("credit return at full count");

endmodule

/* hw/rv32Decode.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module rv32Decode (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  logic [`INST_W-1:0]   inst,
    output logic                 inReady,
    input  logic                 creditReturn,
    output logic                 decValid,
    output decodePkg::instFmtE   instFmt,
    output logic                 memValid,
    output logic                 memWrite,
    output logic [`MASK_W-1:0]   memMask,
    output decodePkg::memTypeE   memType,
    output decodePkg::cmpTypeE   cmpType,
    output logic                 isBranch,
    output logic                 isJump,
    output decodePkg::aluOpE     aluOp,
    output decodePkg::aluSrc1E   aluSrc1,
    output decodePkg::aluSrc2E   aluSrc2,
    output decodePkg::rdSrcE     rdSrc,
    output logic                 isEcall,
    output logic                 isMret,
    output logic                 writeCsr,
    output logic                 stopSim
);
    import decodePkg::*;

    logic [`OPCODE_W-1:0]  opcode;
    logic [`FUNCT3_W-1:0]  funct3;
    logic [`FUNCT7_W-1:0]  funct7;
    logic [`FUNCT12_W-1:0] funct12;
    logic                  accept;                      // upstream handshake
    instClassE             instClass;

    instFmtE               instFmtNxt;                  // comb bundle before the register
    logic                  memValidNxt, memWriteNxt;
    logic [`MASK_W-1:0]    memMaskNxt;
    memTypeE               memTypeNxt;
    cmpTypeE               cmpTypeNxt;
    logic                  isBranchNxt, isJumpNxt;
    aluOpE                 aluOpNxt;
    aluSrc1E               aluSrc1Nxt;
    aluSrc2E               aluSrc2Nxt;
    rdSrcE                 rdSrcNxt;
    logic                  isEcallNxt, isMretNxt, writeCsrNxt, stopSimNxt;

    assign opcode  = inst[`OPCODE_LSB  +: `OPCODE_W];
    assign funct3  = inst[`FUNCT3_LSB  +: `FUNCT3_W];
    assign funct7  = inst[`FUNCT7_LSB  +: `FUNCT7_W];
    assign funct12 = inst[`FUNCT12_LSB +: `FUNCT12_W];
    assign accept  = inValid && inReady;

    opcodeClassifier opcodeClassifier_i (
        .opcode(opcode), .funct3(funct3), .funct12(funct12),
        .instClass(instClass), .instFmt(instFmtNxt),
        .isBranch(isBranchNxt), .isJump(isJumpNxt), .isEcall(isEcallNxt),
        .isMret(isMretNxt), .writeCsr(writeCsrNxt), .stopSim(stopSimNxt)
    );

    memAccessDecoder memAccessDecoder_i (
        .instClass(instClass), .funct3(funct3),
        .memValid(memValidNxt), .memWrite(memWriteNxt),
        .memMask(memMaskNxt), .memType(memTypeNxt)
    );

    execControlDecoder execControlDecoder_i (
        .instClass(instClass), .funct3(funct3), .funct7(funct7),
        .aluOp(aluOpNxt), .cmpType(cmpTypeNxt), .aluSrc1(aluSrc1Nxt),
        .aluSrc2(aluSrc2Nxt), .rdSrc(rdSrcNxt)
    );

    creditCounter creditCounter_i (
        .clk(clk), .rstN(rstN), .send(accept),      // credit taken at acceptance
        .creditReturn(creditReturn), .hasCredit(inReady)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= accept;                         // one-cycle pulse per inst
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin                               // payload only, held otherwise
            instFmt  <= instFmtNxt;
            memValid <= memValidNxt;
            memWrite <= memWriteNxt;
            memMask  <= memMaskNxt;
            memType  <= memTypeNxt;
            cmpType  <= cmpTypeNxt;
            isBranch <= isBranchNxt;
            isJump   <= isJumpNxt;
            aluOp    <= aluOpNxt;
            aluSrc1  <= aluSrc1Nxt;
            aluSrc2  <= aluSrc2Nxt;
            rdSrc    <= rdSrcNxt;
            isEcall  <= isEcallNxt;
            isMret   <= isMretNxt;
            writeCsr <= writeCsrNxt;
            stopSim  <= stopSimNxt;
        end
    end

endmodule

/* include/decodeVectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

    // name, inst, fmt, {memValid,memWrite}, mask, memType, cmp, aluOp, {src1,src2}, rdSrc,
    // flags as {isBranch,isJump,isEcall,isMret,writeCsr,stopSim}
    // mask and memType follow funct3 for every class, memory or not
    function automatic void loadVectors();
        addVec("add", 'h003100b3, FMT_R, 'b00, 'h01, MEM_BYTE, CMP_EQ, ALU_ADD, 'b0_00, RD_ALU, 'h00);
        addVec("sub", 'h403100b3, FMT_R, 'b00, 'h01, MEM_BYTE, CMP_EQ, ALU_SUB, 'b0_00, RD_ALU, 'h00);
        addVec("sra", 'h403150b3, FMT_R, 'b00, 'h00, MEM_HALFU, CMP_EQ, ALU_SRA, 'b0_00, RD_ALU, 'h00);
        addVec("srli", 'h00315093, FMT_I, 'b00, 'h00, MEM_HALFU, CMP_EQ, ALU_SRL, 'b0_01, RD_ALU, 'h00);
        addVec("xori", 'h00514093, FMT_I, 'b00, 'h00, MEM_BYTEU, CMP_EQ, ALU_XOR, 'b0_01, RD_ALU, 'h00);
        addVec("ori", 'h00516093, FMT_I, 'b00, 'h00, MEM_BYTE, CMP_EQ, ALU_OR, 'b0_01, RD_ALU, 'h00);
        addVec("andi", 'h00517093, FMT_I, 'b00, 'h00, MEM_BYTE, CMP_EQ, ALU_AND, 'b0_01, RD_ALU, 'h00);
        addVec("sll", 'h003110b3, FMT_R, 'b00, 'h03, MEM_HALF, CMP_EQ, ALU_SLL, 'b0_00, RD_ALU, 'h00);
        addVec("slt", 'h003120b3, FMT_R, 'b00, 'h0f, MEM_WORD, CMP_LT, ALU_SUB, 'b0_00, RD_CMP, 'h00);
        addVec("sltiu", 'h00513093, FMT_I, 'b00, 'h00, MEM_BYTE, CMP_LTU, ALU_SUB, 'b0_01, RD_CMP, 'h00);
        addVec("lui", 'h123450b7, FMT_U, 'b00, 'h00, MEM_HALFU, CMP_EQ, ALU_ADD, 'b0_01, RD_ALU, 'h00);
        addVec("auipc", 'h12345097, FMT_U, 'b00, 'h00, MEM_HALFU, CMP_EQ, ALU_ADD, 'b1_01, RD_ALU, 'h00);
        addVec("lb", 'h00410083, FMT_I, 'b10, 'h01, MEM_BYTE, CMP_EQ, ALU_ADD, 'b0_01, RD_MEM, 'h00);
        addVec("lh", 'h00411083, FMT_I, 'b10, 'h03, MEM_HALF, CMP_EQ, ALU_ADD, 'b0_01, RD_MEM, 'h00);
        addVec("lw", 'h00412083, FMT_I, 'b10, 'h0f, MEM_WORD, CMP_EQ, ALU_ADD, 'b0_01, RD_MEM, 'h00);
        addVec("lbu", 'h00414083, FMT_I, 'b10, 'h00, MEM_BYTEU, CMP_EQ, ALU_ADD, 'b0_01, RD_MEM, 'h00);
        addVec("lhu", 'h00415083, FMT_I, 'b10, 'h00, MEM_HALFU, CMP_EQ, ALU_ADD, 'b0_01, RD_MEM, 'h00);
        addVec("sb", 'h00310223, FMT_S, 'b11, 'h01, MEM_BYTE, CMP_EQ, ALU_ADD, 'b0_01, RD_NONE, 'h00);
        addVec("sh", 'h00311223, FMT_S, 'b11, 'h03, MEM_HALF, CMP_EQ, ALU_ADD, 'b0_01, RD_NONE, 'h00);
        addVec("sw", 'h00312223, FMT_S, 'b11, 'h0f, MEM_WORD, CMP_EQ, ALU_ADD, 'b0_01, RD_NONE, 'h00);
        addVec("beq", 'h00310463, FMT_B, 'b00, 'h01, MEM_BYTE, CMP_EQ, ALU_SUB, 'b0_00, RD_NONE, 'h20);
        addVec("bne", 'h00311463, FMT_B, 'b00, 'h03, MEM_HALF, CMP_NE, ALU_SUB, 'b0_00, RD_NONE, 'h20);
        addVec("blt", 'h00314463, FMT_B, 'b00, 'h00, MEM_BYTEU, CMP_LT, ALU_SUB, 'b0_00, RD_NONE, 'h20);
        addVec("bge", 'h00315463, FMT_B, 'b00, 'h00, MEM_HALFU, CMP_GE, ALU_SUB, 'b0_00, RD_NONE, 'h20);
        addVec("bltu", 'h00316463, FMT_B, 'b00, 'h00, MEM_BYTE, CMP_LTU, ALU_SUB, 'b0_00, RD_NONE, 'h20);
        addVec("bgeu", 'h00317463, FMT_B, 'b00, 'h00, MEM_BYTE, CMP_GEU, ALU_SUB, 'b0_00, RD_NONE, 'h20);
        addVec("jal", 'h010000ef, FMT_J, 'b00, 'h01, MEM_BYTE, CMP_EQ, ALU_ADD, 'b0_01, RD_SNPC, 'h10);
        addVec("jalr", 'h000100e7, FMT_I, 'b00, 'h01, MEM_BYTE, CMP_EQ, ALU_ADD, 'b0_01, RD_SNPC, 'h10);
        addVec("csrrw", 'h300110f3, FMT_N, 'b00, 'h03, MEM_HALF, CMP_EQ, ALU_ADD, 'b0_10, RD_CSR, 'h02);
        addVec("ecall", 'h00000073, FMT_N, 'b00, 'h01, MEM_BYTE, CMP_EQ, ALU_ADD, 'b0_01, RD_CSR, 'h0a);
        addVec("mret", 'h30200073, FMT_N, 'b00, 'h01, MEM_BYTE, CMP_EQ, ALU_ADD, 'b0_01, RD_NONE, 'h04);
        addVec("ebreak", 'h00100073, FMT_N, 'b00, 'h01, MEM_BYTE, CMP_EQ, ALU_ADD, 'b0_01, RD_NONE, 'h01);
        addVec("unknown", 'h0000000b, FMT_N, 'b00, 'h01, MEM_BYTE, CMP_EQ, ALU_ADD, 'b0_01, RD_NONE, 'h01);
    endfunction

`endif

/* verification/rv32DecodeTb.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module rv32DecodeTb;
    import decodePkg::*;

    typedef struct {
        string       name;
        logic [31:0] inst;
        instFmtE     fmt;
        logic [1:0]  memVW;                             // {memValid, memWrite}
        logic [7:0]  mask;
        memTypeE     memType;
        cmpTypeE     cmp;
        aluOpE       alu;
        logic [2:0]  src;                               // {aluSrc1, aluSrc2}
        rdSrcE       rd;
        logic [5:0]  flags;                             // branch, jump, ecall, mret, csr, stop
    } vecT;

    logic               clk, rstN, inValid, inReady, creditReturn, decValid;
    logic [`INST_W-1:0] inst;
    instFmtE            instFmt;
    logic               memValid, memWrite;
    logic [`MASK_W-1:0] memMask;
    memTypeE            memType;
    cmpTypeE            cmpType;
    logic               isBranch, isJump;
    aluOpE              aluOp;
    aluSrc1E            aluSrc1;
    aluSrc2E            aluSrc2;
    rdSrcE              rdSrc;
    logic               isEcall, isMret, writeCsr, stopSim;

    vecT         vecs[$];
    int          expQ[$];                               // accepted rows awaiting a bundle
    int          pendQ[$];                              // due cycle of each credit return
    logic [15:0] lfsr;
    logic        holdCredits;                           // consumer withholds returns
    int          cycleCnt = 0;
    int          bundleCnt = 0;
    int          returnCnt = 0;
    int          mismatchErrs = 0;
    int          protocolErrs = 0;

    rv32Decode rv32Decode_i (.*);

    always #10 clk = ~clk;                              // 20 ns period

    function automatic void addVec(input string n, input logic [31:0] i, input instFmtE f,
                                   input logic [1:0] vw, input logic [7:0] mk,
                                   input memTypeE mt, input cmpTypeE c, input aluOpE a,
                                   input logic [2:0] s, input rdSrcE r, input logic [5:0] fl);
        vecT v;
        v = '{n, i, f, vw, mk, mt, c, a, s, r, fl};
        vecs.push_back(v);
    endfunction

    `include "decodeVectors.svh"

    // galois lfsr, taps for x^16+x^14+x^13+x^11+1
    function automatic logic nextBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ 16'hb400;
        end
        return outBit;
    endfunction

    task automatic checkField(input string tName, input string fName,
                              input logic [7:0] expVal, input logic [7:0] actVal);
        assert (actVal === expVal) else begin
            mismatchErrs++;
            $display("ERR %s %s: expected %0h, actual %0h", tName, fName, expVal, actVal);
        end
    endtask

    // called right after a rising edge, returns on the edge that accepts
    task automatic sendInst(input int idx);
        logic taken;
        taken = 1'b0;
        inValid <= 1'b1;
        inst    <= vecs[idx].inst;
        while (!taken) begin
            @(negedge clk);
            taken = inReady;                            // handshake at coming edge
            @(posedge clk);
        end
        expQ.push_back(idx);
    endtask

    // consumer: checks each bundle in order, schedules its credit
    always @(negedge clk) begin
        vecT        v;
        logic [1:0] delay;
        if (rstN && decValid) begin
            bundleCnt++;
            assert (bundleCnt - returnCnt <= `DECODE_CREDITS) else begin
                protocolErrs++;
                $display("more bundles outstanding than credits granted");
            end
            assert (expQ.size() != 0) else begin
                protocolErrs++;
                $display("bundle arrived with no instruction accepted");
            end
            if (expQ.size() != 0) begin
                v = vecs[expQ.pop_front()];
                checkField(v.name, "instFmt", v.fmt, instFmt);
                checkField(v.name, "memValid", v.memVW[1], memValid);
                checkField(v.name, "memWrite", v.memVW[0], memWrite);
                checkField(v.name, "memMask", v.mask, memMask);
                checkField(v.name, "memType", v.memType, memType);
                checkField(v.name, "cmpType", v.cmp, cmpType);
                checkField(v.name, "aluOp", v.alu, aluOp);
                checkField(v.name, "aluSrc1", v.src[2], aluSrc1);
                checkField(v.name, "aluSrc2", v.src[1:0], aluSrc2);
                checkField(v.name, "rdSrc", v.rd, rdSrc);
                checkField(v.name, "isBranch", v.flags[5], isBranch);
                checkField(v.name, "isJump", v.flags[4], isJump);
                checkField(v.name, "isEcall", v.flags[3], isEcall);
                checkField(v.name, "isMret", v.flags[2], isMret);
                checkField(v.name, "writeCsr", v.flags[1], writeCsr);
                checkField(v.name, "stopSim", v.flags[0], stopSim);
            end
            delay[1] = nextBit();                       // 0..3 cycles
            delay[0] = nextBit();
            pendQ.push_back(cycleCnt + 1 + delay);
        end
    end

    always @(posedge clk) begin
        cycleCnt++;
        if (creditReturn) begin
            returnCnt++;                                // dut takes it at this edge
        end
        if (!holdCredits && (pendQ.size() != 0) && (pendQ[0] <= cycleCnt)) begin
            void'(pendQ.pop_front());
            creditReturn <= 1'b1;
        end else begin
            creditReturn <= 1'b0;
        end
    end

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        inValid      = 1'b0;
        inst         = '0;
        creditReturn = 1'b0;
        holdCredits  = 1'b1;                            // first rows see no returns
        lfsr         = 16'd42982;
        loadVectors();
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        assert (!decValid && inReady) else begin
            protocolErrs++;
            $display("after reset decValid should be low and inReady high");
        end
        @(posedge clk);
        sendInst(0);
        sendInst(1);
        inValid <= 1'b1;                                // third row waits for a credit
        inst    <= vecs[2].inst;
        repeat (6) begin
            @(negedge clk);
            assert (!inReady) else begin
                protocolErrs++;
                $display("inReady went high while every credit was held");
            end
        end
        @(posedge clk);
        assert (bundleCnt == `DECODE_CREDITS) else begin
            protocolErrs++;
            $display("ERR creditHold: expected %0d, actual %0d", `DECODE_CREDITS, bundleCnt);
        end
        @(negedge clk);
        holdCredits = 1'b0;                             // random returns from here on
        @(posedge clk);
        for (int i = 2; i < vecs.size(); i++) begin
            sendInst(i);
        end
        inValid <= 1'b0;
        inst    <= '0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);                      // catch any stray bundle
        assert (bundleCnt == vecs.size()) else begin
            protocolErrs++;
            $display("ERR bundleCount: expected %0d, actual %0d", vecs.size(), bundleCnt);
        end
        $display("errors: %0d field mismatches, %0d protocol", mismatchErrs, protocolErrs);
        if (mismatchErrs + protocolErrs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        @(posedge clk);                                 // table is loaded by now
        #((vecs.size() + 8) * 8 * 20);
        $display("timeout: the decode run did not complete in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* rv32Decode.f */
+incdir+include
hw/decodePkg.sv
hw/opcodeClassifier.sv
hw/memAccessDecoder.sv
hw/execControlDecoder.sv
hw/creditCounter.sv
hw/rv32Decode.sv
verification/rv32DecodeTb.sv

/* Bender.yml */
package:
  name: rv32Decode

export_include_dirs:
  - include

sources:
  - files:
      - hw/decodePkg.sv
      - hw/opcodeClassifier.sv
      - hw/memAccessDecoder.sv
      - hw/execControlDecoder.sv
      - hw/creditCounter.sv
      - hw/rv32Decode.sv
  - target: test
    files:
      - verification/rv32DecodeTb.sv
